//--- dv/tb_vp8_residual_enc.sv
/* Testbench top for the residual encoder: clock, reset, random block
   stimulus, DUT and checker instances, watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_vp8_residual_enc;
    import vp8_enc_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_GAP      = 3;
    localparam int DRAIN_CYCLES = PIPE_LATENCY + 2;
    localparam int N_ZERO = 8, N_RAND = 300, N_EXT = 8, N_BURST = 16;
    localparam int N_TAIL = 40, N_SWEEP = 16, N_CFG = 40;
    localparam int NUM_STARTS  = N_ZERO + N_RAND + N_EXT + N_BURST + N_TAIL + N_SWEEP + N_CFG;
    localparam int IDLE_BUDGET = RESET_CYCLES + NUM_STARTS * MAX_GAP + 8 * DRAIN_CYCLES + 4;
    localparam int WATCHDOG_NS = (NUM_STARTS + IDLE_BUDGET + 100) * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       flush;
    pix_blk_t   src, pred, base, bump;
    quant_cfg_t quant_cfg;
    level_blk_t levels;
    coef_blk_t  dqcoef;
    logic       nz;
    logic [3:0] last;
    logic       done;
    int         data_errs, timing_errs, proto_errs;
    int         total_errs;

    vp8_residual_enc dut_i (
        .clk (clk), .rst_n (rst_n), .start_i (start), .src_i (src), .pred_i (pred),
        .quant_cfg_i (quant_cfg), .levels_o (levels), .dqcoef_o (dqcoef),
        .nz_o (nz), .last_o (last), .done_o (done)
    );

    vp8_enc_checker vp8_enc_checker (
        .clk (clk), .rst_n (rst_n), .start_i (start), .src_i (src), .pred_i (pred),
        .cfg_i (quant_cfg), .levels_i (levels), .dqcoef_i (dqcoef), .nz_i (nz),
        .last_i (last), .done_i (done), .flush_i (flush), .data_errs_o (data_errs),
        .timing_errs_o (timing_errs), .proto_errs_o (proto_errs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [QFIX-1:0] recip(int q);
        int r;
        r = (1 << QFIX) / q;
        if (r > (1 << QFIX) - 1) r = (1 << QFIX) - 1;  // q of 1 saturates
        return QFIX'(r);
    endfunction

    function automatic quant_cfg_t make_cfg(int q_dc, int q_ac);
        quant_cfg_t cfg;
        cfg.q_dc    = COEF_W'(q_dc);
        cfg.q_ac    = COEF_W'(q_ac);
        cfg.iq_dc   = recip(q_dc);
        cfg.iq_ac   = recip(q_ac);
        cfg.bias_dc = QFIX'(110 << 9);
        cfg.bias_ac = QFIX'(96 << 9);
        return cfg;
    endfunction

    function automatic pix_blk_t rand_blk();
        pix_blk_t b;
        for (int k = 0; k < BLK_PIX; k++) b[k] = 8'($urandom);
        return b;
    endfunction

    function automatic pix_blk_t pattern_blk(int kind);
        pix_blk_t b;
        for (int k = 0; k < BLK_PIX; k++) begin
            case (kind)
                0:       b[k] = 8'hff;
                1:       b[k] = (((k / 4) + k) % 2 == 0) ? 8'hff : 8'h00;  // Checkerboard
                2:       b[k] = (k % 2 == 0) ? 8'hff : 8'h00;
                default: b[k] = (k < 8) ? 8'hff : 8'h00;
            endcase
        end
        return b;
    endfunction

    task automatic issue_block(input pix_blk_t s, input pix_blk_t p);
        @(posedge clk);
        #1;
        start = 1'b1;
        src   = s;
        pred  = p;
    endtask

    task automatic hold_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            start = 1'b0;
        end
    endtask

    task automatic run_random(input int n);
        for (int i = 0; i < n; i++) begin
            issue_block(rand_blk(), rand_blk());
            hold_idle($urandom_range(0, MAX_GAP));
        end
        hold_idle(DRAIN_CYCLES);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'he7d1));
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        flush     = 1'b0;
        src       = '0;
        pred      = '0;
        quant_cfg = make_cfg(20, 28);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int i = 0; i < N_ZERO; i++) begin  // Zero residual
            base = rand_blk();
            issue_block(base, base);
            hold_idle($urandom_range(0, MAX_GAP));
        end
        hold_idle(DRAIN_CYCLES);

        run_random(N_RAND);

        quant_cfg = make_cfg(1, 1);             // Extreme residuals, smallest step
        for (int i = 0; i < N_EXT / 2; i++) begin
            issue_block(pattern_blk(i), ~pattern_blk(i));
            issue_block(~pattern_blk(i), pattern_blk(i));
        end
        hold_idle(DRAIN_CYCLES);

        quant_cfg = make_cfg(20, 28);
        for (int i = 0; i < N_BURST; i++) issue_block(rand_blk(), rand_blk());
        run_random(N_TAIL);

        quant_cfg = make_cfg(80, 80);           // Single pixel sweep, coarse step
        for (int k = 0; k < N_SWEEP; k++) begin
            base    = rand_blk();
            bump    = base;
            bump[k] = (base[k] < 8'd128) ? base[k] + 8'd120 : base[k] - 8'd120;
            issue_block(bump, base);
            hold_idle($urandom_range(0, MAX_GAP));
        end
        hold_idle(DRAIN_CYCLES);

        quant_cfg = make_cfg(40, 52);           // New matrix while idle
        run_random(N_CFG);

        flush = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        total_errs = data_errs + timing_errs + proto_errs;
        $display("Error counts: data %0d, timing %0d, protocol %0d",
                 data_errs, timing_errs, proto_errs);
        if (total_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the test sequence did not complete", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/vp8_enc_checker.sv
/* Scoreboard for the residual encoder: bit-exact DCT, quantizer and zigzag
   model, expected result queue, latency check and error counters */
`timescale 1ns/1ps
`default_nettype none

module vp8_enc_checker (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire vp8_enc_pkg::pix_blk_t    src_i,
    input  wire vp8_enc_pkg::pix_blk_t    pred_i,
    input  wire vp8_enc_pkg::quant_cfg_t  cfg_i,
    input  wire vp8_enc_pkg::level_blk_t  levels_i,
    input  wire vp8_enc_pkg::coef_blk_t   dqcoef_i,
    input  wire logic                     nz_i,
    input  wire logic [3:0]               last_i,
    input  wire logic                     done_i,
    input  wire logic                     flush_i,    // End of test, queue must be empty
    output int                            data_errs_o,
    output int                            timing_errs_o,
    output int                            proto_errs_o
);
    import vp8_enc_pkg::*;

    typedef struct packed {
        level_blk_t levels;
        coef_blk_t  dqcoef;
        logic       nz;
        logic [3:0] last;
    } expect_t;

    // VP8 coefficient scan order
    localparam int SCAN_ORDER [BLK_PIX] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    expect_t                 exp_q [$];
    expect_t                 exp_head;
    logic [PIPE_LATENCY-1:0] start_hist;
    logic                    flushed;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic coef_blk_t fdct_model(pix_blk_t s, pix_blk_t p);
        int        r [BLK_PIX];
        int        t [BLK_PIX];
        int        a0, a1, a2, a3;
        coef_blk_t out;
        for (int k = 0; k < BLK_PIX; k++) r[k] = int'(s[k]) - int'(p[k]);
        for (int i = 0; i < 4; i++) begin      // Horizontal pass
            a0 = r[4*i] + r[4*i+3];
            a1 = r[4*i+1] + r[4*i+2];
            a2 = r[4*i+1] - r[4*i+2];
            a3 = r[4*i] - r[4*i+3];
            t[4*i]   = (a0 + a1) * 8;
            t[4*i+1] = (a2 * DCT_K1 + a3 * DCT_K2 + 1812) >>> 9;
            t[4*i+2] = (a0 - a1) * 8;
            t[4*i+3] = (a3 * DCT_K1 - a2 * DCT_K2 + 937) >>> 9;
        end
        for (int c = 0; c < 4; c++) begin      // Vertical pass
            a0 = t[c] + t[c+12];
            a1 = t[c+4] + t[c+8];
            a2 = t[c+4] - t[c+8];
            a3 = t[c] - t[c+12];
            out[c]    = COEF_W'((a0 + a1 + 7) >>> 4);
            out[c+4]  = COEF_W'(((a2 * DCT_K1 + a3 * DCT_K2 + 12000) >>> 16) + ((a3 != 0) ? 1 : 0));
            out[c+8]  = COEF_W'((a0 - a1 + 7) >>> 4);
            out[c+12] = COEF_W'((a3 * DCT_K1 - a2 * DCT_K2 + 51000) >>> 16);
        end
        return out;
    endfunction

    function automatic void quant_model(input coef_blk_t c, input quant_cfg_t cfg,
                                        output level_blk_t lv, output coef_blk_t dq);
        longint v, mag, q, iq, bias, lvl;
        for (int k = 0; k < BLK_PIX; k++) begin
            v    = longint'($signed(c[k]));
            q    = (k == 0) ? cfg.q_dc : cfg.q_ac;
            iq   = (k == 0) ? cfg.iq_dc : cfg.iq_ac;
            bias = (k == 0) ? cfg.bias_dc : cfg.bias_ac;
            mag  = (v < 0) ? -v : v;
            lvl  = (mag * iq + bias) >> QFIX;
            if (lvl > MAX_LEVEL) lvl = MAX_LEVEL;
            if (v < 0) lvl = -lvl;
            lv[k] = LEVEL_W'(lvl);
            dq[k] = COEF_W'(lvl * q);
        end
    endfunction

    function automatic expect_t build_expect(pix_blk_t s, pix_blk_t p, quant_cfg_t cfg);
        level_blk_t lv;
        coef_blk_t  dq;
        expect_t    e;
        quant_model(fdct_model(s, p), cfg, lv, dq);
        e        = '0;
        e.dqcoef = dq;
        for (int j = 0; j < BLK_PIX; j++) begin
            e.levels[j] = lv[SCAN_ORDER[j]];
            if (lv[SCAN_ORDER[j]] != '0) begin
                e.nz   = 1'b1;
                e.last = 4'(j);
            end
        end
        return e;
    endfunction

    task automatic compare_result(input expect_t e);
        if (levels_i !== e.levels) begin
            $display("[ERROR] levels_o expected %h actual %h at %0t", e.levels, levels_i, $time);
            data_errs_o++;
        end
        if (dqcoef_i !== e.dqcoef) begin
            $display("[ERROR] dqcoef_o expected %h actual %h at %0t", e.dqcoef, dqcoef_i, $time);
            data_errs_o++;
        end
        if (nz_i !== e.nz) begin
            $display("[ERROR] nz_o expected %h actual %h at %0t", e.nz, nz_i, $time);
            data_errs_o++;
        end
        if (last_i !== e.last) begin
            $display("[ERROR] last_o expected %h actual %h at %0t", e.last, last_i, $time);
            data_errs_o++;
        end
    endtask

    // ------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_q.delete();
            start_hist <= '0;
            flushed    <= 1'b0;
        end else begin
            if (done_i) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected done_o pulse with no block in flight at %0t", $time);
                    proto_errs_o++;
                end else begin
                    exp_head = exp_q.pop_front();
                    compare_result(exp_head);
                end
            end
            if (done_i !== start_hist[PIPE_LATENCY-1]) begin  // Latency from start history
                $display("[ERROR] done_o expected %h actual %h at %0t",
                         start_hist[PIPE_LATENCY-1], done_i, $time);
                timing_errs_o++;
            end
            start_hist <= {start_hist[PIPE_LATENCY-2:0], start_i};
            if (start_i) exp_q.push_back(build_expect(src_i, pred_i, cfg_i));
            if (flush_i && !flushed) begin
                flushed <= 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d blocks were started but never produced a result", exp_q.size());
                    proto_errs_o++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- files.f
hw/vp8_enc_pkg.sv
hw/vp8_fdct4x4.sv
hw/vp8_quant4x4.sv
hw/vp8_zigzag_scan.sv
hw/vp8_residual_enc.sv
dv/vp8_enc_checker.sv
dv/tb_vp8_residual_enc.sv

//--- hw/vp8_enc_pkg.sv
/* Shared definitions for the VP8 residual front end: block geometry,
   DCT and quantizer constants, zigzag table, block and config types */
`default_nettype none

package vp8_enc_pkg;

    // ------------------------------------------------------------
    // Block geometry
    // ------------------------------------------------------------
    localparam int BLK_DIM = 4;
    localparam int BLK_PIX = BLK_DIM * BLK_DIM;
    localparam int PIX_W   = 8;
    localparam int ROW_W   = 14;  // Row pass stage register width
    localparam int COEF_W  = 12;
    localparam int LEVEL_W = 12;

    // ------------------------------------------------------------
    // Transform and quantizer constants
    // ------------------------------------------------------------
    localparam int DCT_K1     = 2217;
    localparam int DCT_K2     = 5352;
    localparam int DCT_R_ROW1 = 1812;   // Row pass odd term rounding
    localparam int DCT_R_ROW3 = 937;
    localparam int DCT_R_COL1 = 12000;  // Column pass odd term rounding
    localparam int DCT_R_COL3 = 51000;

    localparam int MAX_LEVEL = 2047;
    localparam int QFIX      = 17;

    localparam int FDCT_LATENCY = 2;
    localparam int PIPE_LATENCY = 4;

    // Raster index for each zigzag position
    localparam logic [3:0] ZIGZAG [BLK_PIX] = '{
        4'd0, 4'd1,  4'd4,  4'd8,  4'd5,  4'd2,  4'd3,  4'd6,
        4'd9, 4'd12, 4'd13, 4'd10, 4'd7,  4'd11, 4'd14, 4'd15
    };

    // ------------------------------------------------------------
    // Block and config types
    // ------------------------------------------------------------
    typedef logic [BLK_PIX-1:0][PIX_W-1:0]   pix_blk_t;
    typedef logic [BLK_PIX-1:0][COEF_W-1:0]  coef_blk_t;
    typedef logic [BLK_PIX-1:0][LEVEL_W-1:0] level_blk_t;

    typedef struct packed {
        logic [COEF_W-1:0] q_dc;
        logic [COEF_W-1:0] q_ac;
        logic [QFIX-1:0]   iq_dc;     // 2^QFIX / q
        logic [QFIX-1:0]   iq_ac;
        logic [QFIX-1:0]   bias_dc;
        logic [QFIX-1:0]   bias_ac;
    } quant_cfg_t;

    typedef struct packed {
        level_blk_t level;
        coef_blk_t  dequant;
    } quant_res_t;

endpackage

`default_nettype wire

//--- hw/vp8_fdct4x4.sv
/* Residual and VP8 4x4 integer forward DCT, row pass then column pass,
   each stage registered */
`timescale 1ns/1ps
`default_nettype none

module vp8_fdct4x4 (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start_i,
    input  wire vp8_enc_pkg::pix_blk_t  src_i,
    input  wire vp8_enc_pkg::pix_blk_t  ref_i,
    output vp8_enc_pkg::coef_blk_t      coef_o,
    output logic                        done_o
);
    import vp8_enc_pkg::*;

    logic signed [PIX_W:0]   resid   [BLK_PIX];  // 9b src - ref
    logic signed [ROW_W-1:0] row_nxt [BLK_PIX];
    logic signed [ROW_W-1:0] row_q   [BLK_PIX];
    coef_blk_t               col_nxt;
    logic                    start_d;

    for (genvar k = 0; k < BLK_PIX; k++) begin : g_resid
        assign resid[k] = $signed({1'b0, src_i[k]}) - $signed({1'b0, ref_i[k]});
    end

    // ------------------------------------------------------------
    // Row pass
    // ------------------------------------------------------------
    for (genvar r = 0; r < BLK_DIM; r++) begin : g_row
        logic signed [ROW_W-1:0] b0, b1, b2, b3;
        logic signed [31:0]      p1, p3;

        assign b0 = resid[BLK_DIM*r+0] + resid[BLK_DIM*r+3];
        assign b1 = resid[BLK_DIM*r+1] + resid[BLK_DIM*r+2];
        assign b2 = resid[BLK_DIM*r+1] - resid[BLK_DIM*r+2];
        assign b3 = resid[BLK_DIM*r+0] - resid[BLK_DIM*r+3];

        assign p1 = b2 * DCT_K1 + b3 * DCT_K2 + DCT_R_ROW1;
        assign p3 = b3 * DCT_K1 - b2 * DCT_K2 + DCT_R_ROW3;

        assign row_nxt[BLK_DIM*r+0] = (b0 + b1) <<< 3;  // DC and middle scaled by 8
        assign row_nxt[BLK_DIM*r+1] = ROW_W'(p1 >>> 9);
        assign row_nxt[BLK_DIM*r+2] = (b0 - b1) <<< 3;
        assign row_nxt[BLK_DIM*r+3] = ROW_W'(p3 >>> 9);
    end

    // ------------------------------------------------------------
    // Column pass
    // ------------------------------------------------------------
    for (genvar c = 0; c < BLK_DIM; c++) begin : g_col
        logic signed [ROW_W:0] d0, d1, d2, d3;  // 15b
        logic signed [31:0]    s0, s2;
        logic signed [31:0]    e1, e3;
        logic signed [31:0]    t1;

        assign d0 = row_q[c]     + row_q[c + 12];
        assign d1 = row_q[c + 4] + row_q[c + 8];
        assign d2 = row_q[c + 4] - row_q[c + 8];
        assign d3 = row_q[c]     - row_q[c + 12];

        assign s0 = d0 + d1 + 7;
        assign s2 = d0 - d1 + 7;
        assign e1 = d2 * DCT_K1 + d3 * DCT_K2 + DCT_R_COL1;
        assign e3 = d3 * DCT_K1 - d2 * DCT_K2 + DCT_R_COL3;

        // Row 1 gets +1 for nonzero d3
        assign t1 = (e1 >>> 16) + ((d3 != '0) ? 32'sd1 : 32'sd0);

        assign col_nxt[c]      = COEF_W'(s0 >>> 4);
        assign col_nxt[c + 4]  = COEF_W'(t1);
        assign col_nxt[c + 8]  = COEF_W'(s2 >>> 4);
        assign col_nxt[c + 12] = COEF_W'(e3 >>> 16);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q  <= '{default: '0};
            coef_o <= '0;
        end else begin
            row_q  <= row_nxt;   // Stage 1
            coef_o <= col_nxt;   // Stage 2
        end
    end

    // Start strobe follows the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            start_d <= start_i;
            done_o  <= start_d;
        end
    end

    a_done_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        done_o |-> $past(start_i, FDCT_LATENCY)
    );

endmodule

`default_nettype wire

//--- hw/vp8_quant4x4.sv
/* Quantizer for one 4x4 coefficient block: signed levels with clipping
   plus dequantized coefficients for reconstruction */
`timescale 1ns/1ps
`default_nettype none

module vp8_quant4x4 (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire vp8_enc_pkg::coef_blk_t   coef_i,
    input  wire vp8_enc_pkg::quant_cfg_t  cfg_i,
    output vp8_enc_pkg::quant_res_t       res_o,
    output logic                          done_o
);
    import vp8_enc_pkg::*;

    localparam int SCALE_W = COEF_W + QFIX + 1;

    quant_res_t res_nxt;

    // ------------------------------------------------------------
    // Per coefficient datapath
    // ------------------------------------------------------------
    for (genvar k = 0; k < BLK_PIX; k++) begin : g_coef
        logic signed [COEF_W-1:0]  coef;
        logic                      neg;
        logic [COEF_W-1:0]         mag;       // |coef|, 2048 fits unsigned
        logic [COEF_W-1:0]         q;
        logic [QFIX-1:0]           iq;
        logic [QFIX-1:0]           bias;
        logic [SCALE_W-1:0]        scaled;
        logic [SCALE_W-QFIX-1:0]   qmag;
        logic [LEVEL_W-1:0]        lvl_mag;
        logic signed [LEVEL_W-1:0] lvl;
        logic signed [LEVEL_W+COEF_W:0] dq;

        // DC step only at raster 0
        assign q    = (k == 0) ? cfg_i.q_dc    : cfg_i.q_ac;
        assign iq   = (k == 0) ? cfg_i.iq_dc   : cfg_i.iq_ac;
        assign bias = (k == 0) ? cfg_i.bias_dc : cfg_i.bias_ac;

        assign coef = $signed(coef_i[k]);
        assign neg  = coef[COEF_W-1];
        assign mag  = neg ? COEF_W'(-coef) : COEF_W'(coef);

        assign scaled = SCALE_W'(mag) * SCALE_W'(iq) + SCALE_W'(bias);
        assign qmag   = scaled[SCALE_W-1:QFIX];

        assign lvl_mag = (qmag > (SCALE_W-QFIX)'(MAX_LEVEL)) ? LEVEL_W'(MAX_LEVEL)
                                                              : LEVEL_W'(qmag);
        assign lvl     = neg ? -$signed(lvl_mag) : $signed(lvl_mag);

        assign dq = lvl * $signed({1'b0, q});

        assign res_nxt.level[k]   = lvl;
        assign res_nxt.dequant[k] = dq[COEF_W-1:0];  // Truncated to coefficient width
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_o  <= '0;
            done_o <= 1'b0;
        end else begin
            res_o  <= res_nxt;
            done_o <= start_i;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_step_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_i |-> (cfg_i.q_dc != '0) && (cfg_i.q_ac != '0)
    );

    for (genvar k = 0; k < BLK_PIX; k++) begin : g_chk
        a_level_clip: assert property (
            @(posedge clk) disable iff (!rst_n)
            done_o |-> ($signed(res_o.level[k]) <= MAX_LEVEL)
                    && ($signed(res_o.level[k]) >= -MAX_LEVEL)
        );
    end

endmodule

`default_nettype wire

//--- hw/vp8_residual_enc.sv
/* Top of the residual coding front end: forward DCT, quantizer
   and zigzag scan in a four cycle pipeline */
`timescale 1ns/1ps
`default_nettype none

module vp8_residual_enc (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire vp8_enc_pkg::pix_blk_t    src_i,
    input  wire vp8_enc_pkg::pix_blk_t    pred_i,
    input  wire vp8_enc_pkg::quant_cfg_t  quant_cfg_i,
    output vp8_enc_pkg::level_blk_t       levels_o,
    output vp8_enc_pkg::coef_blk_t        dqcoef_o,
    output logic                          nz_o,
    output logic [3:0]                    last_o,
    output logic                          done_o
);
    import vp8_enc_pkg::*;

    coef_blk_t  coef;
    logic       fdct_done;
    quant_res_t qres;
    logic       quant_done;

    // ------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------
    vp8_fdct4x4 u_fdct (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .src_i   (src_i),
        .ref_i   (pred_i),
        .coef_o  (coef),
        .done_o  (fdct_done)
    );

    vp8_quant4x4 u_quant (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (fdct_done),
        .coef_i  (coef),
        .cfg_i   (quant_cfg_i),   // Held static while blocks are in flight
        .res_o   (qres),
        .done_o  (quant_done)
    );

    vp8_zigzag_scan u_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (quant_done),
        .res_i    (qres),
        .levels_o (levels_o),
        .dqcoef_o (dqcoef_o),
        .nz_o     (nz_o),
        .last_o   (last_o),
        .done_o   (done_o)
    );

endmodule

`default_nettype wire

//--- hw/vp8_zigzag_scan.sv
/* Zigzag reorder of quantized levels and last nonzero search,
   registered together with the dequantized block */
`timescale 1ns/1ps
`default_nettype none

module vp8_zigzag_scan (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     start_i,
    input  wire vp8_enc_pkg::quant_res_t  res_i,
    output vp8_enc_pkg::level_blk_t       levels_o,
    output vp8_enc_pkg::coef_blk_t        dqcoef_o,
    output logic                          nz_o,
    output logic [3:0]                    last_o,
    output logic                          done_o
);
    import vp8_enc_pkg::*;

    level_blk_t zz_lvl;
    logic       nz_nxt;
    logic [3:0] last_nxt;

    // ------------------------------------------------------------
    // Reorder
    // ------------------------------------------------------------
    for (genvar j = 0; j < BLK_PIX; j++) begin : g_zz
        assign zz_lvl[j] = res_i.level[ZIGZAG[j]];
    end

    // Highest zigzag position wins
    always_comb begin
        nz_nxt   = 1'b0;
        last_nxt = '0;
        for (int j = 0; j < BLK_PIX; j++) begin
            if (zz_lvl[j] != '0) begin
                nz_nxt   = 1'b1;
                last_nxt = 4'(j);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levels_o <= '0;
            dqcoef_o <= '0;
            nz_o     <= 1'b0;
            last_o   <= '0;
            done_o   <= 1'b0;
        end else begin
            levels_o <= zz_lvl;
            dqcoef_o <= res_i.dequant;   // Stays in raster order
            nz_o     <= nz_nxt;
            last_o   <= last_nxt;
            done_o   <= start_i;
        end
    end

    a_last_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        nz_o |-> (levels_o[last_o] != '0)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the residual encoder testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -sv -Wno-fatal \
    --top-module tb_vp8_residual_enc \
    -Mdir obj_dir -o tb_vp8_residual_enc \
    -f files.f

./obj_dir/tb_vp8_residual_enc | tee "$LOG"

if grep -q "^=== PASS ===$" "$LOG"; then
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
